// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module PipelineExecuteTb -f files.f -o simv
	./obj_dir/simv | tee sim.log
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/DecodedInstIf.sv
interface DecodedInstIf
#(
    parameter DATA_WIDTH = 32,
    parameter REG_WIDTH  = 5);

    logic                  Valid;          // Slot holds an instruction
    Types::AluOp           AluControl;     // ALU operation
    Types::OperandASel     OperandASel;    // Operand A source
    Types::OperandBSel     OperandBSel;    // Operand B source
    logic [DATA_WIDTH-1:0] Imm;            // Sign-extended immediate
    logic [REG_WIDTH-1:0]  Rd;             // Destination register
    logic                  RegWrEn;        // Write back to register file
    logic                  MemRdEn;        // Load
    logic                  MemWrEn;        // Store

    // Decoder side
    modport source (output Valid, AluControl, OperandASel, OperandBSel, Imm, Rd,
                           RegWrEn, MemRdEn, MemWrEn);
    // ID/EX register input side
    modport sink   (input  Valid, AluControl, OperandASel, OperandBSel, Imm, Rd,
                           RegWrEn, MemRdEn, MemWrEn);
    // Registered bundle, driven by ID/EX and read by EX and EX/MEM
    modport exec   (output Valid, AluControl, OperandASel, OperandBSel, Imm, Rd,
                           RegWrEn, MemRdEn, MemWrEn);

endinterface

// File: design/ExMemRegister.sv
module ExMemRegister
#(
    parameter DATA_WIDTH = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_arstN,
    DecodedInstIf.exec            exIf,         // Valid, Rd and flags
    input  logic [DATA_WIDTH-1:0] i_Result,     // From StageEX
    input  logic [DATA_WIDTH-1:0] i_DataB,      // Store data
    output logic                  o_Valid,
    output logic [DATA_WIDTH-1:0] o_Result,     // ALU result or address
    output logic [DATA_WIDTH-1:0] o_DataB,
    output logic [REG_WIDTH-1:0]  o_RegAddr,    // Destination register
    output logic                  o_RegWrEn,
    output logic                  o_MemRdEn,
    output logic                  o_MemWrEn);

    // --------------------------------------------------
    // Control towards MEM, cleared on reset
    // --------------------------------------------------
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_Valid   <= 1'b0;
            o_RegWrEn <= 1'b0;
            o_MemRdEn <= 1'b0;
            o_MemWrEn <= 1'b0;
        end else begin
            o_Valid   <= exIf.Valid;
            o_RegWrEn <= exIf.RegWrEn;              // Already gated in ID/EX
            o_MemRdEn <= exIf.MemRdEn;
            o_MemWrEn <= exIf.MemWrEn;
        end
    end

    always_ff @(posedge i_Clock) begin
        o_Result  <= i_Result;
        o_DataB   <= i_DataB;
        o_RegAddr <= exIf.Rd;
    end

endmodule

// File: design/IdExRegister.sv
module IdExRegister
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32)
(
    input  logic                  i_Clock,
    input  logic                  i_arstN,
    DecodedInstIf.sink            decIf,        // From decoder
    input  logic [DATA_WIDTH-1:0] i_DataA,      // RS1 value
    input  logic [DATA_WIDTH-1:0] i_DataB,      // RS2 value
    input  logic [PC_WIDTH-1:0]   i_PC,
    DecodedInstIf.exec            exIf,         // Registered bundle
    output logic [DATA_WIDTH-1:0] o_DataA,
    output logic [DATA_WIDTH-1:0] o_DataB,
    output logic [PC_WIDTH-1:0]   o_PC);

    // --------------------------------------------------
    // Valid and flags, bubbles carry no writes
    // --------------------------------------------------
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            exIf.Valid   <= 1'b0;
            exIf.RegWrEn <= 1'b0;
            exIf.MemRdEn <= 1'b0;
            exIf.MemWrEn <= 1'b0;
        end else begin
            exIf.Valid   <= decIf.Valid;
            exIf.RegWrEn <= decIf.Valid & decIf.RegWrEn;
            exIf.MemRdEn <= decIf.Valid & decIf.MemRdEn;
            exIf.MemWrEn <= decIf.Valid & decIf.MemWrEn;
        end
    end

    // Payload, captured every cycle
    always_ff @(posedge i_Clock) begin
        exIf.AluControl  <= decIf.AluControl;
        exIf.OperandASel <= decIf.OperandASel;
        exIf.OperandBSel <= decIf.OperandBSel;
        exIf.Imm         <= decIf.Imm;
        exIf.Rd          <= decIf.Rd;
        o_DataA          <= i_DataA;
        o_DataB          <= i_DataB;
        o_PC             <= i_PC;
    end

endmodule

// File: design/InstDecoder.sv
module InstDecoder
(
    input  logic         i_Valid,           // Instruction strobe
    input  logic [31:0]  i_Inst,            // Raw instruction word
    DecodedInstIf.source decIf);            // Decoded bundle

    RiscvIsa::Opcode    opcode;
    logic [2:0]         funct3;
    logic               altBit;             // Instruction bit 30
    logic signed [31:0] immI;
    logic signed [31:0] immS;
    logic signed [31:0] immU;
    logic signed [31:0] immJ;
    logic signed [31:0] immSel;             // Immediate picked by opcode
    Types::AluOp        aluOp;

    // --------------------------------------------------
    // Field split and immediate formats
    // --------------------------------------------------
    assign opcode = RiscvIsa::Opcode'(i_Inst[RiscvIsa::OPCODE_POS +: 7]);
    assign funct3 = i_Inst[RiscvIsa::FUNCT3_POS +: 3];
    assign altBit = i_Inst[RiscvIsa::FUNCT7_ALT_BIT];

    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};
    assign immS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
    assign immU = {i_Inst[31:12], 12'b0};
    assign immJ = {{12{i_Inst[31]}}, i_Inst[19:12], i_Inst[20], i_Inst[30:21], 1'b0};

    assign decIf.Valid      = i_Valid;                          // Passed through as is
    assign decIf.Rd         = i_Inst[RiscvIsa::RD_POS +: 5];
    assign decIf.Imm        = immSel;                           // Signed, so extends
    assign decIf.AluControl = aluOp;

    // --------------------------------------------------
    // ALU operation from funct3 and bit 30
    // --------------------------------------------------
    always_comb begin
        aluOp = Types::ADD;                                     // Address and link adds
        if (opcode == RiscvIsa::OP || opcode == RiscvIsa::OP_IMM) begin
            case (funct3)
                RiscvIsa::F3_ADD_SUB: begin
                    if (altBit && opcode == RiscvIsa::OP) aluOp = Types::SUB;   // No SUBI
                    else                                  aluOp = Types::ADD;
                end
                RiscvIsa::F3_SLL:     aluOp = Types::SLL;
                RiscvIsa::F3_SLT:     aluOp = Types::SLT;
                RiscvIsa::F3_SLTU:    aluOp = Types::SLTU;
                RiscvIsa::F3_XOR:     aluOp = Types::XOR;
                RiscvIsa::F3_SRL_SRA: begin
                    if (altBit) aluOp = Types::SRA;             // SRA and SRAI
                    else        aluOp = Types::SRL;
                end
                RiscvIsa::F3_OR:      aluOp = Types::OR;
                RiscvIsa::F3_AND:     aluOp = Types::AND;
                default:              aluOp = Types::ADD;
            endcase
        end
    end

    // --------------------------------------------------
    // Operand selects, immediate format and flags
    // --------------------------------------------------
    always_comb begin
        decIf.OperandASel = Types::RS1;
        decIf.OperandBSel = Types::RS2;
        decIf.RegWrEn     = 1'b0;                               // Unknown opcode writes nothing
        decIf.MemRdEn     = 1'b0;
        decIf.MemWrEn     = 1'b0;
        immSel            = immI;
        case (opcode)
            RiscvIsa::OP: begin
                decIf.RegWrEn = 1'b1;
            end
            RiscvIsa::OP_IMM: begin
                decIf.OperandBSel = Types::IMM;
                decIf.RegWrEn     = 1'b1;
            end
            RiscvIsa::LUI: begin
                decIf.OperandASel = Types::ZERO;                // 0 + imm
                decIf.OperandBSel = Types::IMM;
                decIf.RegWrEn     = 1'b1;
                immSel            = immU;
            end
            RiscvIsa::AUIPC: begin
                decIf.OperandASel = Types::PC;
                decIf.OperandBSel = Types::IMM;
                decIf.RegWrEn     = 1'b1;
                immSel            = immU;
            end
            RiscvIsa::JAL, RiscvIsa::JALR: begin
                decIf.OperandASel = Types::PC;                  // Link value PC+4
                decIf.OperandBSel = Types::FOUR;
                decIf.RegWrEn     = 1'b1;
                if (opcode == RiscvIsa::JAL) immSel = immJ;
            end
            RiscvIsa::LOAD: begin
                decIf.OperandBSel = Types::IMM;                 // Address = rs1 + offset
                decIf.RegWrEn     = 1'b1;
                decIf.MemRdEn     = 1'b1;
            end
            RiscvIsa::STORE: begin
                decIf.OperandBSel = Types::IMM;
                decIf.MemWrEn     = 1'b1;
                immSel            = immS;
            end
            default: ;
        endcase
    end

endmodule

// File: design/IntegerALU.sv
module IntegerALU
#(
    parameter DATA_WIDTH = 32)
(
    input  Types::AluOp           i_Op,         // Operation
    input  logic [DATA_WIDTH-1:0] i_OperandA,
    input  logic [DATA_WIDTH-1:0] i_OperandB,
    output logic [DATA_WIDTH-1:0] o_Result);

    logic [4:0] shamt;                          // RV32I shift amount
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = i_OperandB[4:0];
    assign ltSigned   = $signed(i_OperandA) < $signed(i_OperandB);
    assign ltUnsigned = i_OperandA < i_OperandB;

    // --------------------------------------------------
    // Ten integer operations
    // --------------------------------------------------
    always_comb begin
        case (i_Op)
            Types::ADD:  o_Result = i_OperandA + i_OperandB;
            Types::SUB:  o_Result = i_OperandA - i_OperandB;
            Types::SLL:  o_Result = i_OperandA << shamt;
            Types::SLT:  o_Result = DATA_WIDTH'(ltSigned);      // 0 or 1
            Types::SLTU: o_Result = DATA_WIDTH'(ltUnsigned);
            Types::XOR:  o_Result = i_OperandA ^ i_OperandB;
            Types::SRL:  o_Result = i_OperandA >> shamt;
            Types::SRA:  o_Result = $signed(i_OperandA) >>> shamt;  // Sign fills
            Types::OR:   o_Result = i_OperandA | i_OperandB;
            Types::AND:  o_Result = i_OperandA & i_OperandB;
            default:     o_Result = '0;                         // Unused codes
        endcase
    end

endmodule

// File: design/PipelineExecute.sv
module PipelineExecute
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_arstN,
    input  logic                  i_Valid,      // One-cycle instruction strobe
    input  logic [31:0]           i_Inst,
    input  logic [PC_WIDTH-1:0]   i_PC,
    input  logic [DATA_WIDTH-1:0] i_DataA,      // RS1 read earlier
    input  logic [DATA_WIDTH-1:0] i_DataB,      // RS2 read earlier
    output logic                  o_Valid,      // Two cycles after i_Valid
    output logic [DATA_WIDTH-1:0] o_Result,
    output logic [DATA_WIDTH-1:0] o_DataB,
    output logic [REG_WIDTH-1:0]  o_RegAddr,
    output logic                  o_RegWrEn,
    output logic                  o_MemRdEn,
    output logic                  o_MemWrEn);

    logic [DATA_WIDTH-1:0] idExDataA;
    logic [DATA_WIDTH-1:0] idExDataB;
    logic [PC_WIDTH-1:0]   idExPC;
    logic [DATA_WIDTH-1:0] exResult;
    logic [DATA_WIDTH-1:0] exDataB;

    DecodedInstIf #(.DATA_WIDTH (DATA_WIDTH), .REG_WIDTH (REG_WIDTH)) decIf ();  // ID side
    DecodedInstIf #(.DATA_WIDTH (DATA_WIDTH), .REG_WIDTH (REG_WIDTH)) exIf ();   // EX side

    // --------------------------------------------------
    // Decode, then ID/EX
    // --------------------------------------------------
    InstDecoder decoder (
        .i_Valid (i_Valid),
        .i_Inst  (i_Inst),
        .decIf   (decIf));

    IdExRegister #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH))
    idEx (
        .i_Clock (i_Clock),
        .i_arstN (i_arstN),
        .decIf   (decIf),
        .i_DataA (i_DataA),
        .i_DataB (i_DataB),
        .i_PC    (i_PC),
        .exIf    (exIf),
        .o_DataA (idExDataA),
        .o_DataB (idExDataB),
        .o_PC    (idExPC));

    // --------------------------------------------------
    // Execute, then EX/MEM
    // --------------------------------------------------
    StageEX #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH))
    stageEx (
        .exIf     (exIf),
        .i_DataA  (idExDataA),
        .i_DataB  (idExDataB),
        .i_PC     (idExPC),
        .o_Result (exResult),
        .o_DataB  (exDataB));

    ExMemRegister #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    exMem (
        .i_Clock   (i_Clock),
        .i_arstN   (i_arstN),
        .exIf      (exIf),
        .i_Result  (exResult),
        .i_DataB   (exDataB),
        .o_Valid   (o_Valid),
        .o_Result  (o_Result),
        .o_DataB   (o_DataB),
        .o_RegAddr (o_RegAddr),
        .o_RegWrEn (o_RegWrEn),
        .o_MemRdEn (o_MemRdEn),
        .o_MemWrEn (o_MemWrEn));

endmodule

// File: design/RiscvIsa.sv
package RiscvIsa;

    // --------------------------------------------------
    // Major opcodes, bits [6:0]
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,    // Register-register
        OP_IMM = 7'b0010011,    // Register-immediate
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } Opcode;

    // funct3 of the integer ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;    // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;    // Split by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;    // LW and SW width

    // Field LSB positions inside the instruction word
    localparam int OPCODE_POS = 0;                 // 7 bits
    localparam int RD_POS     = 7;                 // 5 bits
    localparam int FUNCT3_POS = 12;                // 3 bits
    localparam int RS1_POS    = 15;                // 5 bits
    localparam int RS2_POS    = 20;                // 5 bits
    localparam int FUNCT7_POS = 25;                // 7 bits

    localparam int FUNCT7_ALT_BIT = 30;            // SUB and SRA select

endpackage

// File: design/StageEX.sv
module StageEX
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32)
(
    DecodedInstIf.exec            exIf,         // Selects, ALU op, immediate
    input  logic [DATA_WIDTH-1:0] i_DataA,      // RS1 value
    input  logic [DATA_WIDTH-1:0] i_DataB,      // RS2 value
    input  logic [PC_WIDTH-1:0]   i_PC,         // Instruction address
    output logic [DATA_WIDTH-1:0] o_Result,     // ALU result
    output logic [DATA_WIDTH-1:0] o_DataB);     // Store data

    logic [DATA_WIDTH-1:0] operandA;
    logic [DATA_WIDTH-1:0] operandB;

    // --------------------------------------------------
    // Operand A: RS1, PC or zero
    // --------------------------------------------------
    always_comb begin
        case (exIf.OperandASel)
            Types::RS1: operandA = i_DataA;
            Types::PC:  operandA = DATA_WIDTH'(i_PC);   // Zero-extended
            default:    operandA = '0;                  // ZERO, LUI path
        endcase
    end

    // --------------------------------------------------
    // Operand B: RS2, immediate or four
    // --------------------------------------------------
    always_comb begin
        case (exIf.OperandBSel)
            Types::RS2:  operandB = i_DataB;
            Types::IMM:  operandB = exIf.Imm;
            Types::FOUR: operandB = DATA_WIDTH'(4);     // Link offset
            default:     operandB = i_DataB;
        endcase
    end

    IntegerALU #(
        .DATA_WIDTH (DATA_WIDTH))
    alu (
        .i_Op       (exIf.AluControl),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .o_Result   (o_Result));

    assign o_DataB = i_DataB;                           // RS2 passes through for stores

endmodule

// File: design/Types.sv
package Types;

    // --------------------------------------------------
    // ALU operation, one code per RV32I integer op
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ADD,                    // A + B
        SUB,                    // A - B
        SLL,                    // Logical left shift
        SLT,                    // Signed compare
        SLTU,                   // Unsigned compare
        XOR,
        SRL,                    // Logical right shift
        SRA,                    // Arithmetic right shift
        OR,
        AND
    } AluOp;

    // Operand A source
    typedef enum logic [1:0] {
        RS1  = 2'd0,            // Register operand
        PC   = 2'd1,            // Instruction address
        ZERO = 2'd2             // Constant zero, for LUI
    } OperandASel;

    // Operand B source
    typedef enum logic [1:0] {
        RS2  = 2'd0,            // Register operand
        IMM  = 2'd1,            // Decoded immediate
        FOUR = 2'd2             // Link offset for jumps
    } OperandBSel;

endpackage

// File: files.f
design/Types.sv
design/RiscvIsa.sv
design/DecodedInstIf.sv
design/IntegerALU.sv
design/InstDecoder.sv
design/IdExRegister.sv
design/StageEX.sv
design/ExMemRegister.sv
design/PipelineExecute.sv
testbench/PipelineExecute_assert.sv
testbench/PipelineExecuteTb.sv

// File: testbench/PipelineExecuteTb.sv
module PipelineExecuteTb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] dataB;                 // Store data
        logic [4:0]  rd;
        logic        regWr;
        logic        memRd;
        logic        memWr;
        logic [31:0] cycle;                 // Cycle of the issuing negedge
    } Expected;

    logic        i_Clock;
    logic        i_arstN;
    logic        i_Valid;
    logic [31:0] i_Inst;
    logic [31:0] i_PC;
    logic [31:0] i_DataA;
    logic [31:0] i_DataB;
    logic        o_Valid;
    logic [31:0] o_Result;
    logic [31:0] o_DataB;
    logic [4:0]  o_RegAddr;
    logic        o_RegWrEn;
    logic        o_MemRdEn;
    logic        o_MemWrEn;

    Expected     expQ[$];                   // Outstanding instructions in issue order
    integer      seed = 32'ha6e3;
    logic [31:0] cycleCount = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    PipelineExecute DUT (.*);

    initial begin
        i_Clock = 1'b0;
        forever #4 i_Clock = ~i_Clock;      // 8 ns period
    end

    always @(posedge i_Clock) cycleCount <= cycleCount + 1;

    task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Reference encoder and RV32I semantics
    // --------------------------------------------------
    function automatic logic [31:0] encR(logic [2:0] f3, logic alt, logic [4:0] rd);
        return {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, rd, RiscvIsa::OP};
    endfunction

    function automatic logic [31:0] encI(RiscvIsa::Opcode op, logic [2:0] f3,
                                         logic [11:0] imm, logic [4:0] rd);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, RiscvIsa::F3_WORD, imm[4:0], RiscvIsa::STORE};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, RiscvIsa::JAL};
    endfunction

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt,
                                           logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];                                    // RV32I uses five shift bits
        case (f3)
            RiscvIsa::F3_ADD_SUB: return alt ? a - b : a + b;
            RiscvIsa::F3_SLL:     return a << sh;
            RiscvIsa::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            RiscvIsa::F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            RiscvIsa::F3_XOR:     return a ^ b;
            RiscvIsa::F3_SRL_SRA: begin
                if (alt) return 32'($signed(a) >>> sh);  // Sign fill
                return a >> sh;
            end
            RiscvIsa::F3_OR:      return a | b;
            default:              return a & b;
        endcase
    endfunction

    function automatic Expected makeExp(logic [31:0] result, logic [31:0] dataB,
                                        logic [4:0] rd, logic regWr, logic memRd, logic memWr);
        Expected e;
        e = '{result, dataB, rd, regWr, memRd, memWr, 32'd0};
        return e;
    endfunction

    // --------------------------------------------------
    // Drivers on the falling edge
    // --------------------------------------------------
    task automatic issue(logic [31:0] inst, logic [31:0] pc, logic [31:0] a,
                         logic [31:0] b, Expected exp);
        @(negedge i_Clock);
        i_Valid   = 1'b1;
        i_Inst    = inst;
        i_PC      = pc;
        i_DataA   = a;
        i_DataB   = b;
        exp.cycle = cycleCount;
        expQ.push_back(exp);
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(negedge i_Clock);
            i_Valid = 1'b0;                             // Held word still decodes to live flags
        end
    endtask

    // Waits until every queued result has come out
    task automatic drain();
        int waitCycles;
        waitCycles = 0;
        idle(1);
        while (expQ.size() != 0 && waitCycles < 20) begin
            @(negedge i_Clock);
            waitCycles++;
        end
        if (expQ.size() != 0) begin
            otherErrors++;
            $display("Timeout: %0d result(s) never came out of the pipeline", expQ.size());
            expQ.delete();
        end
    endtask

    task automatic sendR(logic [2:0] f3, logic alt);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        a  = $random(seed);
        b  = $random(seed);
        rd = 5'($random(seed));
        issue(encR(f3, alt, rd), $random(seed), a, b, makeExp(aluRef(f3, alt, a, b), b, rd,
              1'b1, 1'b0, 1'b0));
    endtask

    task automatic sendImm(logic [2:0] f3, logic [11:0] imm, logic [31:0] a);
        logic        alt;
        logic [31:0] b;
        logic [4:0]  rd;
        alt = (f3 == RiscvIsa::F3_SRL_SRA) && imm[10];  // Only SRAI uses bit 30
        b   = $random(seed);
        rd  = 5'($random(seed));
        issue(encI(RiscvIsa::OP_IMM, f3, imm, rd), $random(seed), a, b,
              makeExp(aluRef(f3, alt, a, {{20{imm[11]}}, imm}), b, rd, 1'b1, 1'b0, 1'b0));
    endtask

    task automatic sendUpper(RiscvIsa::Opcode op, logic [19:0] imm, logic [31:0] pc);
        logic [31:0] base;
        logic [4:0]  rd;
        base = (op == RiscvIsa::LUI) ? 32'd0 : pc;
        rd   = 5'($random(seed));
        issue({imm, rd, op}, pc, $random(seed), 32'd0,
              makeExp(base + {imm, 12'b0}, 32'd0, rd, 1'b1, 1'b0, 1'b0));
    endtask

    task automatic sendJump(RiscvIsa::Opcode op, logic [31:0] pc);
        logic [31:0] inst;
        logic [4:0]  rd;
        rd   = 5'($random(seed));
        inst = (op == RiscvIsa::JAL) ? encJ(21'($random(seed)), rd)
                                     : encI(RiscvIsa::JALR, 3'd0, 12'($random(seed)), rd);
        issue(inst, pc, $random(seed), 32'd0, makeExp(pc + 32'd4, 32'd0, rd, 1'b1, 1'b0, 1'b0));
    endtask

    task automatic sendMem(logic isStore, logic [31:0] a, logic [31:0] b, logic [11:0] off);
        logic [31:0] inst;
        logic [4:0]  rd;
        rd   = 5'($random(seed));
        inst = isStore ? encS(off) : encI(RiscvIsa::LOAD, RiscvIsa::F3_WORD, off, rd);
        issue(inst, $random(seed), a, b, makeExp(a + {{20{off[11]}}, off}, b, rd,
              !isStore, !isStore, isStore));
    endtask

    // --------------------------------------------------
    // Output monitor comparing every o_Valid pulse
    // --------------------------------------------------
    always @(negedge i_Clock) begin
        Expected exp;
        if (i_arstN && o_Valid) begin
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Unexpected o_Valid at %0d ns with nothing outstanding", $time);
            end else begin
                exp = expQ.pop_front();
                checkValue("latency", cycleCount - exp.cycle, 32'd2);
                checkValue("o_Result", o_Result, exp.result);
                if (exp.memWr) checkValue("o_DataB", o_DataB, exp.dataB);
                if (exp.regWr) checkValue("o_RegAddr", 32'(o_RegAddr), 32'(exp.rd));
                checkValue("o_RegWrEn", 32'(o_RegWrEn), 32'(exp.regWr));
                checkValue("o_MemRdEn", 32'(o_MemRdEn), 32'(exp.memRd));
                checkValue("o_MemWrEn", 32'(o_MemWrEn), 32'(exp.memWr));
            end
        end else if (i_arstN) begin
            checkValue("idle flags", 32'({o_RegWrEn, o_MemRdEn, o_MemWrEn}), 32'd0);
        end
    end

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic testReset();
        i_arstN = 1'b0;
        repeat (10) begin
            @(negedge i_Clock);
            checkValue("reset outputs", 32'({o_Valid, o_RegWrEn, o_MemRdEn, o_MemWrEn}), 32'd0);
        end
        i_arstN = 1'b1;                                 // Released on a falling edge
        @(negedge i_Clock);
        checkValue("post-reset outputs", 32'({o_Valid, o_RegWrEn, o_MemRdEn, o_MemWrEn}), 32'd0);
    endtask

    task automatic testRType();
        logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic       alts [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        for (int k = 0; k < 10; k++) begin
            repeat (3) sendR(f3s[k], alts[k]);          // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
        end
        drain();
    endtask

    task automatic testOpImm();
        sendImm(RiscvIsa::F3_ADD_SUB, 12'hFFF, 32'h0000_0010);  // ADDI -1
        sendImm(RiscvIsa::F3_ADD_SUB, 12'h800, 32'h0000_0100);  // Most negative offset
        sendImm(RiscvIsa::F3_SLT,     12'hFFB, 32'hFFFF_FFF0);
        sendImm(RiscvIsa::F3_SLTU,    12'hFFF, 32'h7FFF_FFFF);  // Compares against max
        sendImm(RiscvIsa::F3_XOR,     12'hFFF, 32'h1234_5678);  // NOT
        sendImm(RiscvIsa::F3_OR,      12'h0F0, 32'h0000_000F);
        sendImm(RiscvIsa::F3_AND,     12'hF0F, 32'hABCD_EF01);
        sendImm(RiscvIsa::F3_SLL,     12'h005, 32'h8000_0001);
        sendImm(RiscvIsa::F3_SRL_SRA, 12'h004, 32'h8000_1234);  // SRLI
        sendImm(RiscvIsa::F3_SRL_SRA, 12'h404, 32'h8000_1234);  // SRAI
        sendImm(RiscvIsa::F3_SRL_SRA, 12'h41F, 32'hF000_0000);
        drain();
    endtask

    task automatic testUpperJump();
        sendUpper(RiscvIsa::LUI, 20'hABCDE, 32'h0000_4000);
        sendUpper(RiscvIsa::LUI, 20'h80000, 32'h0000_4000);
        sendUpper(RiscvIsa::AUIPC, 20'h00001, 32'h0000_1FFC);
        sendUpper(RiscvIsa::AUIPC, 20'hFFFFF, 32'h0001_0000);   // Negative upper
        sendJump(RiscvIsa::JAL, 32'h0000_0100);
        sendJump(RiscvIsa::JALR, 32'hFFFF_FFFC);                // Link wraps
        drain();
    endtask

    task automatic testLoadStore();
        sendMem(1'b0, 32'h0000_1000, 32'h0, 12'h010);
        sendMem(1'b0, 32'h0000_1000, 32'h0, 12'hFF0);           // Negative offset
        sendMem(1'b1, 32'h0000_2000, 32'hDEAD_BEEF, 12'h7FF);
        sendMem(1'b1, 32'h0000_2000, 32'hCAFE_F00D, 12'h800);
        drain();
    endtask

    task automatic testPipeline();
        logic [2:0] f3;
        logic       alt;
        repeat (60) begin
            f3  = 3'($random(seed));
            alt = 1'($random(seed));
            case (3'($random(seed)) % 5)
                0: sendR(f3, alt && (f3 == 3'd0 || f3 == 3'd5));
                1: sendImm(f3, (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt && f3 == 3'd5, 5'd0,
                           5'($random(seed))} : 12'($random(seed)), $random(seed));
                2: sendUpper(alt ? RiscvIsa::LUI : RiscvIsa::AUIPC, 20'($random(seed)),
                             $random(seed));
                3: sendJump(alt ? RiscvIsa::JAL : RiscvIsa::JALR, $random(seed));
                default: sendMem(alt, $random(seed), $random(seed), 12'($random(seed)));
            endcase
            if ($random(seed) % 4 == 0) idle(1 + 32'($random(seed) & 1));  // Occasional gap
        end
        drain();
    endtask

    initial begin
        i_arstN = 1'b0;
        i_Valid = 1'b0;
        i_Inst  = 32'd0;
        i_PC    = 32'd0;
        i_DataA = 32'd0;
        i_DataB = 32'd0;
        testReset();
        testRType();
        testOpImm();
        testUpperJump();
        testLoadStore();
        testPipeline();
        $display("Errors: %0d value mismatch(es), %0d other failure(s)", valueErrors,
                 otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/PipelineExecute_assert.sv
module PipelineExecuteAssert (
    input logic i_Clock,
    input logic i_arstN,
    input logic i_Valid,                    // Instruction strobe into the DUT
    input logic i_OutValid,                 // o_Valid of the DUT
    input logic i_RegWrEn,
    input logic i_MemRdEn,
    input logic i_MemWrEn);

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // Fixed two-cycle latency, both directions
    // --------------------------------------------------
    assert property (@(posedge i_Clock) disable iff (!i_arstN) i_Valid |-> ##2 i_OutValid)
        else $error("o_Valid missing two cycles after i_Valid");
    assert property (@(posedge i_Clock) disable iff (!i_arstN) !i_Valid |-> ##2 !i_OutValid)
        else $error("o_Valid raised without i_Valid two cycles earlier");

    // Bubbles carry no flags
    assert property (@(posedge i_Clock) disable iff (!i_arstN)
                     (i_RegWrEn || i_MemRdEn || i_MemWrEn) |-> i_OutValid)
        else $error("Flag high while o_Valid is low");

    // Stores never write back
    assert property (@(posedge i_Clock) disable iff (!i_arstN) !(i_MemWrEn && i_RegWrEn))
        else $error("MemWrEn and RegWrEn high together");

endmodule

bind PipelineExecute PipelineExecuteAssert validCheck (
    .i_Clock    (i_Clock),
    .i_arstN    (i_arstN),
    .i_Valid    (i_Valid),
    .i_OutValid (o_Valid),
    .i_RegWrEn  (o_RegWrEn),
    .i_MemRdEn  (o_MemRdEn),
    .i_MemWrEn  (o_MemWrEn));
